//--- list.f
src/sys_pkg.sv
src/mode_wr_if.sv
src/hps_io_sync.sv
src/cmd_decoder.sv
src/video_mode_regs.sv
src/led_ctrl.sv
src/btn_debounce.sv
src/vga_sync_conditioner.sv
src/sys_top.sv
verification/tb_clock_gen.sv
verification/tb_sys_top.sv

//--- src/btn_debounce.sv
`timescale 1ns/1ps

module btn_debounce #(
	parameter logic [31:0] DEB_DIV = 32'd100000
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic btn_n_a,
	input  logic btn_n_b,
	output logic pressed
);

	// Sample divider
	logic [31:0] div;
	logic        tick;
	// Pin synchronizer
	logic [1:0]  press_s;
	// Last eight samples
	logic [7:0]  hist;

	assign tick = (div == DEB_DIV - 1'b1);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div     <= '0;
			press_s <= '0;
			hist    <= '0;
			pressed <= 1'b0;
		end else begin
			// Either pin low counts as a press
			press_s <= {press_s[0], ~(btn_n_a & btn_n_b)};
			if (tick) begin
				div  <= '0;
				hist <= {hist[6:0], press_s[1]};
				// Change only on eight equal samples
				if (&hist) begin
					pressed <= 1'b1;
				end else if (~|hist) begin
					pressed <= 1'b0;
				end
			end else begin
				div <= div + 1'b1;
			end
		end
	end

endmodule

//--- src/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder import sys_pkg::*; (
	input  logic        clk_sys,
	input  logic        resetd,
	input  logic        io_strobe,
	input  io_word_u    io_din,
	input  logic        io_uio,
	mode_wr_if.ctrl     wr,
	output logic        csync_en,
	output led_view_t   led_ovr,
	output logic [4:0]  vol_att
);

	// ==============================
	// Command state
	// ==============================

	logic       has_cmd;
	logic [7:0] cmd;
	// Word count inside a command, stops at 8
	logic [3:0] cnt;
	logic       data_stb;
	logic       tim_wr;

	// Strobe carrying a data word
	assign data_stb = io_uio & io_strobe & has_cmd;
	// Only the first eight timing words
	assign tim_wr   = data_stb & (cmd == CMD_TIMING) & ~cnt[3];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			cmd      <= '0;
			cnt      <= '0;
			csync_en <= 1'b0;
			led_ovr  <= '0;
			vol_att  <= '0;
		end else if (!io_uio) begin
			// Command ends with uio low
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				// First word is the command byte
				has_cmd <= 1'b1;
				cmd     <= io_din.raw[7:0];
				cnt     <= '0;
			end else begin
				case (cmd)
					CMD_CFG: begin
						csync_en <= io_din.cfg.csync;
					end
					CMD_TIMING: begin
						if (!cnt[3]) begin
							cnt <= cnt + 1'b1;
						end
					end
					CMD_LED: begin
						led_ovr <= io_din.led;
					end
					CMD_VOL: begin
						vol_att <= io_din.raw[4:0];
					end
					default: begin
						// Unknown command, data dropped
					end
				endcase
			end
		end
	end

	// ==============================
	// Timing writes
	// ==============================

	// Same cycle as the strobe so registers land one cycle later
	assign wr.wr_en     = tim_wr;
	assign wr.wr_idx    = timing_idx_t'(cnt[2:0]);
	assign wr.wr_data   = io_din.raw[TIM_W-1:0];
	assign wr.seq_start = tim_wr & (cnt == 4'd0);

endmodule

//--- src/hps_io_sync.sv
`timescale 1ns/1ps

module hps_io_sync import sys_pkg::*; (
	input  logic            clk_sys,
	input  logic            resetd,
	input  logic [GP_W-1:0] hps_out,
	input  logic            btn_user,
	input  logic            btn_osd,
	output logic [GP_W-1:0] hps_in,
	output logic            io_strobe,
	output io_word_u        io_din,
	output logic            io_uio
);

	// Two synchronizer stages
	logic [GP_W-1:0] hps_d;
	logic [GP_W-1:0] hps_r;
	// Previous clock sample and ack
	logic rack;
	logic io_ack;
	logic io_clk;
	logic [GP_W-1:0] gp_in;

	assign io_clk = hps_r[GP_IO_CLK];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hps_d     <= '0;
			hps_r     <= '0;
			rack      <= 1'b0;
			io_ack    <= 1'b0;
			io_strobe <= 1'b0;
		end else begin
			hps_d     <= hps_out;
			hps_r     <= hps_d;
			// Rising edge of host clock bit
			io_strobe <= io_clk & ~rack;
			rack      <= io_clk;
			// Ack trails the strobe by one cycle
			io_ack    <= rack;
		end
	end

	// Data and command enable straight from the synced word
	assign io_din.raw = hps_r[IO_W-1:0];
	assign io_uio     = hps_r[GP_IO_UIO];

	// Bit 31 low tells the host the FPGA is configured
	assign gp_in = {1'b0, btn_user, btn_osd, 9'd0, IO_VER, io_ack, 1'b0, {IO_W{1'b0}}};

	// Host reads magic until it raises bit 31
	assign hps_in = hps_out[31] ? gp_in : CORE_MAGIC;

endmodule

//--- src/led_ctrl.sv
`timescale 1ns/1ps

module led_ctrl import sys_pkg::*; (
	input  logic       clk_sys,
	input  logic       resetd,
	input  led_view_t  led_ovr,
	input  logic       core_led_user,
	input  logic [1:0] core_led_power,
	input  logic [1:0] core_led_disk,
	output logic [7:0] led
);

	logic       led_p;
	logic       led_d;
	logic [7:0] status;

	// Power lit only for pattern 2'b10
	assign led_p = core_led_power[1] & ~core_led_power[0];
	// Disk lit on activity or forced on
	assign led_d = core_led_disk[0] | (core_led_disk[1] & ~core_led_disk[0]);
	// Status layout on the board LEDs
	assign status = {3'b000, led_p, 1'b0, led_d, 1'b0, core_led_user};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			led <= '0;
		end else begin
			// Override bit wins per LED
			led <= (led_ovr.overtake & led_ovr.state) | (~led_ovr.overtake & status);
		end
	end

endmodule

//--- src/mode_wr_if.sv
`timescale 1ns/1ps

interface mode_wr_if import sys_pkg::*; ();

	// One write per pulse, no back-pressure
	logic        wr_en;
	timing_idx_t wr_idx;
	timing_t     wr_data;
	// First timing word of a command
	logic        seq_start;

	// Decoder side
	modport ctrl (
		output wr_en,
		output wr_idx,
		output wr_data,
		output seq_start
	);

	// Register file side
	modport regs (
		input wr_en,
		input wr_idx,
		input wr_data,
		input seq_start
	);

endinterface

//--- src/sys_pkg.sv
package sys_pkg;

	// ==============================
	// Widths
	// ==============================

	// Host data word
	localparam int IO_W = 16;
	// Host general purpose words
	localparam int GP_W = 32;
	// One video timing value
	localparam int TIM_W = 12;

	// ==============================
	// Host bus constants
	// ==============================

	// Read back while host bit 31 is low
	localparam logic [GP_W-1:0] CORE_MAGIC = 32'h5CA623A4;
	// Optimized host I/O
	localparam logic [1:0] IO_VER = 2'd1;

	// Bit positions in the host word
	localparam int GP_IO_CLK = 17;
	localparam int GP_IO_UIO = 20;

	// Command codes
	localparam logic [7:0] CMD_CFG    = 8'h01;
	localparam logic [7:0] CMD_TIMING = 8'h20;
	localparam logic [7:0] CMD_LED    = 8'h25;
	localparam logic [7:0] CMD_VOL    = 8'h26;

	// ==============================
	// Types
	// ==============================

	typedef logic [TIM_W-1:0] timing_t;

	// Order of the eight timing words in command 0x20
	typedef enum logic [2:0] {
		IDX_WIDTH,
		IDX_HFP,
		IDX_HS,
		IDX_HBP,
		IDX_HEIGHT,
		IDX_VFP,
		IDX_VS,
		IDX_VBP
	} timing_idx_t;

	// Config word, only csync is used
	typedef struct packed {
		logic [11:0] rsvd_hi;
		logic        csync;
		logic [2:0]  rsvd_lo;
	} cfg_view_t;

	// LED override pair
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_view_t;

	// One data word, decoded per command
	typedef union packed {
		cfg_view_t         cfg;
		led_view_t         led;
		logic [IO_W-1:0]   raw;
	} io_word_u;

endpackage

//--- src/sys_top.sv
`timescale 1ns/1ps

module sys_top import sys_pkg::*; #(
	parameter logic [31:0] DEB_DIV = 32'd100000
) (
	input  logic            clk_sys,
	input  logic            resetd,
	input  logic [GP_W-1:0] hps_out,
	input  logic            btn_user_n,
	input  logic            btn_osd_n,
	input  logic [1:0]      key,
	input  logic            core_vs,
	input  logic            core_hs,
	input  logic            core_led_user,
	input  logic [1:0]      core_led_power,
	input  logic [1:0]      core_led_disk,
	output logic [GP_W-1:0] hps_in,
	output logic [7:0]      led,
	output logic            vga_vs,
	output logic            vga_hs,
	output timing_t         h_total,
	output timing_t         v_total,
	output logic            mode_changed,
	output logic [4:0]      vol_att
);

	// Host bus to decoder
	logic      io_strobe;
	io_word_u  io_din;
	logic      io_uio;
	// Debounced buttons
	logic      btn_user;
	logic      btn_osd;
	// Decoded controls
	logic      csync_en;
	led_view_t led_ovr;

	mode_wr_if mode_wr ();

	// ==============================
	// Host side
	// ==============================

	hps_io_sync hps_io_sync_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.hps_out   (hps_out),
		.btn_user  (btn_user),
		.btn_osd   (btn_osd),
		.hps_in    (hps_in),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.io_uio    (io_uio)
	);

	cmd_decoder cmd_decoder_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.io_uio    (io_uio),
		.wr        (mode_wr.ctrl),
		.csync_en  (csync_en),
		.led_ovr   (led_ovr),
		.vol_att   (vol_att)
	);

	video_mode_regs video_mode_regs_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.wr           (mode_wr.regs),
		.h_total      (h_total),
		.v_total      (v_total),
		.mode_changed (mode_changed)
	);

	// ==============================
	// Board I/O
	// ==============================

	led_ctrl led_ctrl_i (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.led_ovr        (led_ovr),
		.core_led_user  (core_led_user),
		.core_led_power (core_led_power),
		.core_led_disk  (core_led_disk),
		.led            (led)
	);

	// User button shares key 1
	btn_debounce #(.DEB_DIV(DEB_DIV)) btn_user_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.btn_n_a (btn_user_n),
		.btn_n_b (key[1]),
		.pressed (btn_user)
	);

	// OSD button shares key 0
	btn_debounce #(.DEB_DIV(DEB_DIV)) btn_osd_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.btn_n_a (btn_osd_n),
		.btn_n_b (key[0]),
		.pressed (btn_osd)
	);

	vga_sync_conditioner vga_sync_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.core_vs  (core_vs),
		.core_hs  (core_hs),
		.csync_en (csync_en),
		.vga_vs   (vga_vs),
		.vga_hs   (vga_hs)
	);

endmodule

//--- src/vga_sync_conditioner.sv
`timescale 1ns/1ps

module vga_sync_conditioner (
	input  logic clk_sys,
	input  logic resetd,
	input  logic core_vs,
	input  logic core_hs,
	input  logic csync_en,
	output logic vga_vs,
	output logic vga_hs
);

	// Run length counter width
	localparam int RUN_W = 24;

	// Bit 1 vs, bit 0 hs
	logic [1:0] sync_raw;
	logic [1:0] sync_norm;

	assign sync_raw = {core_vs, core_hs};

	// ==============================
	// Polarity measurement
	// ==============================

	for (genvar i = 0; i < 2; i++) begin : g_chan
		logic             s1;
		logic             s2;
		logic [RUN_W-1:0] run_cnt;
		logic [RUN_W-1:0] hi_len;
		logic [RUN_W-1:0] lo_len;
		// High when the sync is active low
		logic             pol;

		always_ff @(posedge clk_sys) begin
			if (resetd) begin
				s1      <= 1'b0;
				s2      <= 1'b0;
				run_cnt <= '0;
				hi_len  <= '0;
				lo_len  <= '0;
				pol     <= 1'b0;
			end else begin
				s1 <= sync_raw[i];
				s2 <= s1;
				// Restart on every edge, saturate otherwise
				if (s1 != s2) begin
					run_cnt <= '0;
				end else if (~&run_cnt) begin
					run_cnt <= run_cnt + 1'b1;
				end
				// Rising edge closes a low run
				if (s1 & ~s2) begin
					lo_len <= run_cnt;
				end
				// Falling edge closes a high run
				if (~s1 & s2) begin
					hi_len <= run_cnt;
				end
				pol <= (hi_len > lo_len);
			end
		end

		// Active high after normalization
		assign sync_norm[i] = sync_raw[i] ^ pol;
	end

	// ==============================
	// Output select
	// ==============================

	// Composite sync on hs, vs held high
	assign vga_vs = csync_en ? 1'b1 : ~sync_norm[1];
	assign vga_hs = csync_en ? ~(sync_norm[1] ^ sync_norm[0]) : ~sync_norm[0];

endmodule

//--- src/video_mode_regs.sv
`timescale 1ns/1ps

module video_mode_regs import sys_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,
	mode_wr_if.regs wr,
	output timing_t h_total,
	output timing_t v_total,
	output logic    mode_changed
);

	// 1920x1080@60 CEA
	localparam timing_t TIM_DEFAULT [8] = '{
		12'd1920, 12'd88, 12'd44, 12'd148,
		12'd1080, 12'd4,  12'd5,  12'd36
	};

	timing_t tim [8];
	logic    differs;

	// New value against stored one
	assign differs = (wr.wr_data != tim[wr.wr_idx]);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			tim          <= TIM_DEFAULT;
			mode_changed <= 1'b0;
		end else if (wr.wr_en) begin
			tim[wr.wr_idx] <= wr.wr_data;
			// Fresh sequence starts from this word's compare
			if (wr.seq_start) begin
				mode_changed <= differs;
			end else if (differs) begin
				mode_changed <= 1'b1;
			end
		end
	end

	// ==============================
	// Totals
	// ==============================

	// One cycle behind the timing registers
	always_ff @(posedge clk_sys) begin
		h_total <= tim[IDX_WIDTH] + tim[IDX_HFP] + tim[IDX_HS] + tim[IDX_HBP];
		v_total <= tim[IDX_HEIGHT] + tim[IDX_VFP] + tim[IDX_VS] + tim[IDX_VBP];
	end

endmodule

//--- verification/io_patterns.txt
// Columns, hex: kind cmd arg n d0 d1 d2 d3 d4 d5 d6 d7 exp_a exp_b exp_c
// Kinds: 1 magic, 2 led, 3 timing, 4 volume, 5 button, 6 sync, 7 reset state
7 00 00 0 0000 0000 0 0  0   0 0 0  898      465  0
1 00 00 0 0000 0000 0 0  0   0 0 0  5CA623A4 0004 0
// LED: arg is {disk[1:0], power[1:0], user}, exp_a is the led byte
2 25 00 1 F0A5 0000 0 0  0   0 0 0  A0 0 0
2 25 01 1 F0A5 0000 0 0  0   0 0 0  A1 0 0
2 25 1E 1 F0A5 0000 0 0  0   0 0 0  A4 0 0
2 25 04 1 0F5A 0000 0 0  0   0 0 0  1A 0 0
2 25 17 1 0F5A 0000 0 0  0   0 0 0  0A 0 0
2 25 0C 1 0F5A 0000 0 0  0   0 0 0  1A 0 0
2 25 1D 1 00FF 0000 0 0  0   0 0 0  15 0 0
// Timing: 1280/110/40/220 and 720/5/5/20, then repeated, then VBP 30
3 20 00 8 0500 006E 28 DC 2D0 5 5 14 672 2EE 1
3 20 00 8 0500 006E 28 DC 2D0 5 5 14 672 2EE 0
3 20 00 8 0500 006E 28 DC 2D0 5 5 1E 672 2F8 1
// Volume: arg 1 sends d1 with uio low afterwards
4 26 01 1 00F3 0026 0 0  0   0 0 0  13 0 0
4 26 00 1 001A 0000 0 0  0   0 0 0  1A 0 0
// Buttons: arg 0 user, arg 1 osd, exp_a is the pressed level
5 00 00 0 0000 0000 0 0  0   0 0 0  1 0 0
5 00 01 0 0000 0000 0 0  0   0 0 0  1 0 0
// Sync: d0 is the config word, exp_a 1 for active-low sources
6 01 00 1 0000 0000 0 0  0   0 0 0  1 0 0
6 01 00 1 0008 0000 0 0  0   0 0 0  1 0 0

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 10
) (
	output logic clk_sys,
	output logic resetd
);

	// 10 ns period
	initial begin
		clk_sys = 1'b0;
		forever begin
			#5 clk_sys = ~clk_sys;
		end
	end

	// Reset held for the first cycles, released just after an edge
	initial begin
		resetd = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clk_sys);
		end
		#1;
		resetd = 1'b0;
	end

endmodule

//--- verification/tb_sys_top.sv
`timescale 1ns/1ps

module tb_sys_top import sys_pkg::*; ();

	// ==============================
	// Pattern layout and limits
	// ==============================

	// kind cmd arg n d0..d7 exp_a exp_b exp_c
	localparam int REC_W   = 15;
	localparam int REC_MAX = 32;
	localparam int F_KIND  = 0;
	localparam int F_CMD   = 1;
	localparam int F_ARG   = 2;
	localparam int F_NUM   = 3;
	localparam int F_D0    = 4;
	localparam int F_EA    = 12;
	localparam int F_EB    = 13;
	localparam int F_EC    = 14;

	// Step kinds
	localparam int K_END      = 0;
	localparam int K_MAGIC    = 1;
	localparam int K_LED      = 2;
	localparam int K_TIMING   = 3;
	localparam int K_VOL      = 4;
	localparam int K_BTN      = 5;
	localparam int K_SYNC     = 6;
	localparam int K_DEFAULTS = 7;

	localparam int ACK_TIMEOUT = 64;
	localparam int BTN_TIMEOUT = 400;
	localparam int RST_TIMEOUT = 40;
	// Sync run: settle first, then compare
	localparam int SYNC_SETTLE = 300;
	localparam int SYNC_CYCLES = 480;
	localparam logic [31:0] TB_DEB_DIV = 32'd4;

	logic            clk_sys;
	logic            resetd;
	logic [GP_W-1:0] hps_out;
	logic            btn_user_n;
	logic            btn_osd_n;
	logic [1:0]      key;
	logic            core_vs;
	logic            core_hs;
	logic            core_led_user;
	logic [1:0]      core_led_power;
	logic [1:0]      core_led_disk;
	logic [GP_W-1:0] hps_in;
	logic [7:0]      led;
	logic            vga_vs;
	logic            vga_hs;
	timing_t         h_total;
	timing_t         v_total;
	logic            mode_changed;
	logic [4:0]      vol_att;

	logic [31:0] pat [REC_W*REC_MAX];
	// Current step fields
	logic [31:0] r_kind;
	logic [31:0] r_cmd;
	logic [31:0] r_arg;
	logic [31:0] r_num;
	logic [31:0] r_d [8];
	logic [31:0] r_ea;
	logic [31:0] r_eb;
	logic [31:0] r_ec;
	int errors;
	int tests;
	int failed_tests;

	tb_clock_gen clock_gen_i (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	sys_top #(.DEB_DIV(TB_DEB_DIV)) sys_top_i (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.hps_out        (hps_out),
		.btn_user_n     (btn_user_n),
		.btn_osd_n      (btn_osd_n),
		.key            (key),
		.core_vs        (core_vs),
		.core_hs        (core_hs),
		.core_led_user  (core_led_user),
		.core_led_power (core_led_power),
		.core_led_disk  (core_led_disk),
		.hps_in         (hps_in),
		.led            (led),
		.vga_vs         (vga_vs),
		.vga_hs         (vga_hs),
		.h_total        (h_total),
		.v_total        (v_total),
		.mode_changed   (mode_changed),
		.vol_att        (vol_att)
	);

	// ==============================
	// Helpers
	// ==============================

	task automatic abort_run(input string why);
		$display("%s at %0t ns", why, $time);
		$display("TEST FAIL");
		$finish;
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic load_rec(input int rec);
		r_kind = pat[rec*REC_W + F_KIND];
		r_cmd  = pat[rec*REC_W + F_CMD];
		r_arg  = pat[rec*REC_W + F_ARG];
		r_num  = pat[rec*REC_W + F_NUM];
		for (int i = 0; i < 8; i++) begin
			r_d[i] = pat[rec*REC_W + F_D0 + i];
		end
		r_ea = pat[rec*REC_W + F_EA];
		r_eb = pat[rec*REC_W + F_EB];
		r_ec = pat[rec*REC_W + F_EC];
	endtask

	function automatic string kind_name(input logic [31:0] k);
		case (k)
			K_MAGIC:    return "magic readback";
			K_LED:      return "led override";
			K_TIMING:   return "video timing";
			K_VOL:      return "volume";
			K_BTN:      return "button";
			K_SYNC:     return "vga sync";
			K_DEFAULTS: return "reset state";
			default:    return "unknown";
		endcase
	endfunction

	// ==============================
	// Compare tasks
	// ==============================

	task automatic check_led(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_total(input string what, input timing_t got, input timing_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string what, input logic [GP_W-1:0] got,
			input logic [GP_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_vol(input string what, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// ==============================
	// Host bus
	// ==============================

	// Ack mirrors the host clock bit
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (hps_in[GP_IO_CLK] !== level) begin
			if (n == ACK_TIMEOUT) begin
				abort_run("host acknowledge did not follow the clock bit");
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic host_toggle(input logic [31:0] word, input logic uio);
		int gap;
		// Bit 31 high so the ack is visible
		hps_out[31]         = 1'b1;
		hps_out[IO_W-1:0]   = word[IO_W-1:0];
		hps_out[GP_IO_UIO]  = uio;
		hps_out[GP_IO_CLK]  = 1'b1;
		wait_ack(1'b1);
		hps_out[GP_IO_CLK]  = 1'b0;
		wait_ack(1'b0);
		gap = $urandom_range(4, 1);
		repeat (gap) begin
			next_cycle();
		end
	endtask

	// Command byte, then r_num data words
	task automatic send_cmd();
		host_toggle(r_cmd, 1'b1);
		for (int i = 0; i < r_num && i < 8; i++) begin
			host_toggle(r_d[i], 1'b1);
		end
		hps_out[GP_IO_UIO] = 1'b0;
		repeat (4) begin
			next_cycle();
		end
	endtask

	task automatic wait_status(input int pos, input logic level);
		int n;
		n = 0;
		while (hps_in[pos] !== level) begin
			if (n == BTN_TIMEOUT) begin
				abort_run("debounced button never reached its level");
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (resetd !== 1'b0) begin
			if (n == RST_TIMEOUT) begin
				abort_run("reset was never released");
			end
			next_cycle();
			n++;
		end
	endtask

	// ==============================
	// Test steps
	// ==============================

	task automatic run_defaults();
		check_total("h_total after reset", h_total, r_ea[TIM_W-1:0]);
		check_total("v_total after reset", v_total, r_eb[TIM_W-1:0]);
		check_flag("mode_changed after reset", mode_changed, r_ec[0]);
		check_led("led after reset", led, 8'h00);
		check_vol("vol_att after reset", vol_att, 5'd0);
	endtask

	task automatic run_magic();
		hps_out[31] = 1'b0;
		next_cycle();
		check_word("magic word", hps_in, r_ea);
		hps_out[31] = 1'b1;
		next_cycle();
		check_word("status word", hps_in, {r_eb[15:0], 16'h0000});
	endtask

	// Arg packs user, power and disk
	task automatic run_led();
		send_cmd();
		core_led_user  = r_arg[0];
		core_led_power = r_arg[2:1];
		core_led_disk  = r_arg[4:3];
		repeat (2) begin
			next_cycle();
		end
		check_led("led mix", led, r_ea[7:0]);
	endtask

	task automatic run_timing();
		send_cmd();
		repeat (2) begin
			next_cycle();
		end
		check_total("h_total", h_total, r_ea[TIM_W-1:0]);
		check_total("v_total", v_total, r_eb[TIM_W-1:0]);
		check_flag("mode_changed", mode_changed, r_ec[0]);
	endtask

	task automatic run_vol();
		send_cmd();
		check_vol("vol_att", vol_att, r_ea[4:0]);
		if (r_arg[0]) begin
			// Toggle with uio low must not reach the decoder as data
			host_toggle(r_d[1], 1'b0);
			repeat (2) begin
				next_cycle();
			end
			check_vol("vol_att after uio low word", vol_att, r_ea[4:0]);
		end
	endtask

	// Arg 0 user on bit 30, arg 1 osd on bit 29
	task automatic run_btn();
		int pos;
		int other;
		pos   = r_arg[0] ? 29 : 30;
		other = r_arg[0] ? 30 : 29;
		hps_out[31] = 1'b1;
		if (r_arg[0]) begin
			btn_osd_n = 1'b0;
		end else begin
			btn_user_n = 1'b0;
		end
		// Eight samples needed, so still released a few cycles in
		repeat (4) begin
			next_cycle();
		end
		check_flag("button before debounce", hps_in[pos], 1'b0);
		wait_status(pos, r_ea[0]);
		check_flag("other button", hps_in[other], 1'b0);
		btn_user_n = 1'b1;
		btn_osd_n  = 1'b1;
		// Still held a few cycles after the pin goes high
		repeat (4) begin
			next_cycle();
		end
		check_flag("button before release debounce", hps_in[pos], r_ea[0]);
		wait_status(pos, 1'b0);
	endtask

	task automatic run_sync();
		io_word_u cfg_w;
		logic     pol_low;
		logic     act_vs;
		logic     act_hs;
		logic     exp_vs;
		logic     exp_hs;
		int       err0;
		cfg_w.raw = r_d[0][IO_W-1:0];
		pol_low   = r_ea[0];
		err0      = errors;
		send_cmd();
		for (int c = 0; c < SYNC_CYCLES; c++) begin
			// Short active runs: hs 4 of 20, vs 8 of 60
			act_hs  = (c % 20) < 4;
			act_vs  = (c % 60) < 8;
			core_hs = act_hs ^ pol_low;
			core_vs = act_vs ^ pol_low;
			@(negedge clk_sys);
			// Normalized syncs are the active levels generated above
			if (cfg_w.cfg.csync) begin
				exp_vs = 1'b1;
				exp_hs = ~(act_vs ^ act_hs);
			end else begin
				exp_vs = ~act_vs;
				exp_hs = ~act_hs;
			end
			// Report only the first mismatch of a run
			if (c >= SYNC_SETTLE && errors == err0) begin
				check_flag("vga_vs", vga_vs, exp_vs);
				check_flag("vga_hs", vga_hs, exp_hs);
			end
			next_cycle();
		end
		core_vs = ~pol_low;
		core_hs = ~pol_low;
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		int rec;
		int err0;
		int unsigned rng_seed;
		hps_out        = '0;
		btn_user_n     = 1'b1;
		btn_osd_n      = 1'b1;
		key            = 2'b11;
		core_vs        = 1'b1;
		core_hs        = 1'b1;
		core_led_user  = 1'b0;
		core_led_power = 2'b00;
		core_led_disk  = 2'b00;
		errors         = 0;
		tests          = 0;
		failed_tests   = 0;
		rng_seed       = 32'hecd8;
		void'($urandom(rng_seed));
		for (int i = 0; i < REC_W*REC_MAX; i++) begin
			pat[i] = '0;
		end
		$readmemh("verification/io_patterns.txt", pat);

		wait_reset_release();
		repeat (3) begin
			next_cycle();
		end

		rec = 0;
		while (rec < REC_MAX && pat[rec*REC_W + F_KIND] != K_END) begin
			load_rec(rec);
			err0 = errors;
			case (r_kind)
				K_DEFAULTS: run_defaults();
				K_MAGIC:    run_magic();
				K_LED:      run_led();
				K_TIMING:   run_timing();
				K_VOL:      run_vol();
				K_BTN:      run_btn();
				K_SYNC:     run_sync();
				default: begin
					$display("pattern file holds an unknown step kind %0d", r_kind);
					errors++;
				end
			endcase
			tests++;
			if (errors != err0) begin
				failed_tests++;
			end
			$display("step %0d %s: %s", rec, kind_name(r_kind),
				(errors == err0) ? "ok" : "mismatch");
			rec++;
		end

		$display("steps %0d, steps with mismatches %0d, mismatches %0d",
			tests, failed_tests, errors);
		if (errors == 0 && tests > 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
